/* design/bht.sv */
`timescale 1ns/100ps

module bht
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // lookup for the word arriving from memory
  input  vaddr_t lookup_pc_i,
  output logic   valid_o,
  output logic   taken_o,
  // training from resolved branches
  input  logic   update_i,
  input  vaddr_t update_pc_i,
  input  logic   update_taken_i
);

  bht_cnt_t               cnt_q [BHT_ENTRIES];
  logic [BHT_ENTRIES-1:0] valid_q;
  bht_idx_t               lookup_idx;
  bht_idx_t               update_idx;
  bht_cnt_t               cnt_d;

  // word aligned, so the index skips the two low bits
  assign lookup_idx = lookup_pc_i[5:2];
  assign update_idx = update_pc_i[5:2];

  // combinational read, msb of the counter is the prediction
  assign valid_o = valid_q[lookup_idx];
  assign taken_o = cnt_q[lookup_idx][1];

  // --------------------
  // counter update
  // --------------------
  always_comb begin
    cnt_d = cnt_q[update_idx];
    if (!valid_q[update_idx]) begin
      // first sighting starts weakly in the resolved direction
      cnt_d = update_taken_i ? bht_cnt_t'(2) : bht_cnt_t'(1);
    end else if (update_taken_i && cnt_q[update_idx] != bht_cnt_t'(3)) begin
      cnt_d = cnt_q[update_idx] + bht_cnt_t'(1);
    end else if (!update_taken_i && cnt_q[update_idx] != bht_cnt_t'(0)) begin
      cnt_d = cnt_q[update_idx] - bht_cnt_t'(1);
    end
  end

  // write lands at the edge, so a lookup sees it next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (update_i) begin
      valid_q[update_idx] <= 1'b1;
      cnt_q[update_idx]   <= cnt_d;
    end
  end

endmodule

/* design/fetch_pkg.sv */
package fetch_pkg;

  // --------------------
  // widths
  // --------------------
  // fetch address, byte granular
  typedef logic [31:0] vaddr_t;
  // one uncompressed instruction word
  typedef logic [31:0] instr_t;
  // saturating two-bit history counter
  typedef logic [1:0]  bht_cnt_t;
  // table index, address bits 5:2
  typedef logic [3:0]  bht_idx_t;

  // --------------------
  // encodings
  // --------------------
  // control flow class of a fetched word
  typedef enum logic [1:0] {
    cf_none,
    cf_branch,
    cf_jump
  } cf_e;

  // pc generator: first cycle after reset loads the boot address
  typedef enum logic {
    pc_boot_load,
    pc_run
  } pc_state_e;

  // --------------------
  // sizes and constants
  // --------------------
  localparam int unsigned BHT_ENTRIES = 16;
  localparam int unsigned QUEUE_DEPTH = 4;
  // uncompressed only, so every step is one word
  localparam int unsigned INSTR_BYTES = 4;

  // rv32i major opcodes seen by the scanner
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

endpackage

/* design/fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  // write side from pc_gen
  input  logic   push_i,
  input  vaddr_t pc_i,
  input  instr_t instr_i,
  input  logic   pred_taken_i,
  input  vaddr_t pred_target_i,
  output logic   space_o,
  // read side toward decode
  output logic   fetch_valid_o,
  input  logic   fetch_ready_i,
  output vaddr_t fetch_pc_o,
  output instr_t fetch_instr_o,
  output logic   fetch_pred_taken_o,
  output vaddr_t fetch_pred_target_o
);

  typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(QUEUE_DEPTH):0]   cnt_t;

  // entry storage
  vaddr_t pc_q     [QUEUE_DEPTH];
  instr_t instr_q  [QUEUE_DEPTH];
  logic   taken_q  [QUEUE_DEPTH];
  vaddr_t target_q [QUEUE_DEPTH];

  ptr_t rd_ptr_q, wr_ptr_q;
  cnt_t cnt_q, cnt_next;
  logic pop;

  assign fetch_valid_o = (cnt_q != '0);
  assign pop           = fetch_valid_o & fetch_ready_i;

  // head stays put until popped, so data is stable under back-pressure
  assign fetch_pc_o          = pc_q[rd_ptr_q];
  assign fetch_instr_o       = instr_q[rd_ptr_q];
  assign fetch_pred_taken_o  = taken_q[rd_ptr_q];
  assign fetch_pred_target_o = target_q[rd_ptr_q];

  // two free slots: one for a push next cycle, one spare
  assign cnt_next = cnt_q + cnt_t'(push_i) - cnt_t'(pop);
  assign space_o  = (cnt_next <= cnt_t'(QUEUE_DEPTH - 2));

  // --------------------
  // pointers and count
  // --------------------
  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      if (pop)    rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      cnt_q <= cnt_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      pc_q[wr_ptr_q]     <= pc_i;
      instr_q[wr_ptr_q]  <= instr_i;
      taken_q[wr_ptr_q]  <= pred_taken_i;
      target_q[wr_ptr_q] <= pred_target_i;
    end
  end

endmodule

/* design/frontend.sv */
`timescale 1ns/100ps

module frontend
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  vaddr_t boot_addr_i,
  // instruction memory, answers one cycle after each request
  output logic   imem_req_o,
  output vaddr_t imem_addr_o,
  input  logic   imem_valid_i,
  input  instr_t imem_rdata_i,
  // decode handshake
  output logic   fetch_valid_o,
  input  logic   fetch_ready_i,
  output vaddr_t fetch_pc_o,
  output instr_t fetch_instr_o,
  output logic   fetch_pred_taken_o,
  output vaddr_t fetch_pred_target_o,
  // resolved control flow from execute
  input  logic   resolve_valid_i,
  input  vaddr_t resolve_pc_i,
  input  logic   resolve_branch_i,
  input  logic   resolve_taken_i,
  input  logic   resolve_mispredict_i,
  input  vaddr_t resolve_target_i,
  // trap entry and return
  input  logic   ex_valid_i,
  input  vaddr_t trap_vector_i,
  input  logic   eret_i,
  input  vaddr_t epc_i
);

  cf_e    scan_cf;
  vaddr_t scan_imm;
  logic   bht_valid, bht_taken;
  logic   bht_update, mispredict;
  logic   queue_space, queue_push, queue_flush;
  vaddr_t resp_pc;
  logic   pred_taken;
  vaddr_t pred_target;

  // only conditional branches train the table
  assign bht_update = resolve_valid_i & resolve_branch_i;
  assign mispredict = resolve_valid_i & resolve_mispredict_i;

  // --------------------
  // scan and predict
  // --------------------
  instr_scan i_instr_scan (
    .instr_i (imem_rdata_i),
    .cf_o    (scan_cf),
    .imm_o   (scan_imm)
  );

  bht i_bht (
    .clk_i,
    .rst_ni,
    .lookup_pc_i    (resp_pc),
    .valid_o        (bht_valid),
    .taken_o        (bht_taken),
    .update_i       (bht_update),
    .update_pc_i    (resolve_pc_i),
    .update_taken_i (resolve_taken_i)
  );

  pc_gen i_pc_gen (
    .clk_i,
    .rst_ni,
    .boot_addr_i,
    .ex_valid_i,
    .trap_vector_i,
    .eret_i,
    .epc_i,
    .mispredict_i        (mispredict),
    .mispredict_target_i (resolve_target_i),
    .resp_valid_i        (imem_valid_i),
    .resp_cf_i           (scan_cf),
    .resp_imm_i          (scan_imm),
    .bht_valid_i         (bht_valid),
    .bht_taken_i         (bht_taken),
    .queue_space_i       (queue_space),
    .imem_req_o,
    .imem_addr_o,
    .resp_pc_o           (resp_pc),
    .push_o              (queue_push),
    .pred_taken_o        (pred_taken),
    .pred_target_o       (pred_target),
    .flush_o             (queue_flush)
  );

  // --------------------
  // queue toward decode
  // --------------------
  fetch_queue i_fetch_queue (
    .clk_i,
    .rst_ni,
    .flush_i             (queue_flush),
    .push_i              (queue_push),
    .pc_i                (resp_pc),
    .instr_i             (imem_rdata_i),
    .pred_taken_i        (pred_taken),
    .pred_target_i       (pred_target),
    .space_o             (queue_space),
    .fetch_valid_o,
    .fetch_ready_i,
    .fetch_pc_o,
    .fetch_instr_o,
    .fetch_pred_taken_o,
    .fetch_pred_target_o
  );

endmodule

/* design/instr_scan.sv */
`timescale 1ns/100ps

module instr_scan
  import fetch_pkg::*;
(
  input  instr_t instr_i,
  output cf_e    cf_o,
  output vaddr_t imm_o
);

  // sign-extended immediates of both formats, picked by opcode below
  vaddr_t b_imm;
  vaddr_t j_imm;

  // b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign b_imm = {{20{instr_i[31]}},
                  instr_i[7],
                  instr_i[30:25],
                  instr_i[11:8],
                  1'b0};

  // j-type: imm[20|10:1|11|19:12] in 31:12
  assign j_imm = {{12{instr_i[31]}},
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  // classify on the major opcode only
  always_comb begin
    cf_o  = cf_none;
    imm_o = '0;
    case (instr_i[6:0])
      OPCODE_BRANCH: begin
        cf_o  = cf_branch;
        imm_o = b_imm;
      end
      OPCODE_JAL: begin
        cf_o  = cf_jump;
        imm_o = j_imm;
      end
      // jalr and everything else is left to execute
      default: begin
        cf_o  = cf_none;
        imm_o = '0;
      end
    endcase
  end

endmodule

/* design/pc_gen.sv */
`timescale 1ns/100ps

module pc_gen
  import fetch_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  vaddr_t    boot_addr_i,
  // redirects from the back end
  input  logic      ex_valid_i,
  input  vaddr_t    trap_vector_i,
  input  logic      eret_i,
  input  vaddr_t    epc_i,
  input  logic      mispredict_i,
  input  vaddr_t    mispredict_target_i,
  // word arriving from memory, already scanned
  input  logic      resp_valid_i,
  input  cf_e       resp_cf_i,
  input  vaddr_t    resp_imm_i,
  input  logic      bht_valid_i,
  input  logic      bht_taken_i,
  // queue keeps room for the request in flight
  input  logic      queue_space_i,
  output logic      imem_req_o,
  output vaddr_t    imem_addr_o,
  output vaddr_t    resp_pc_o,
  output logic      push_o,
  output logic      pred_taken_o,
  output vaddr_t    pred_target_o,
  output logic      flush_o
);

  pc_state_e state_q, state_d;
  // next address to request
  vaddr_t    npc_q, npc_d;
  // address of the request answered this cycle
  vaddr_t    resp_pc_q;

  assign resp_pc_o   = resp_pc_q;
  assign imem_addr_o = npc_q;

  // any back-end redirect kills the arriving word and the queue
  assign flush_o = ex_valid_i | eret_i | mispredict_i;
  assign push_o  = resp_valid_i & ~flush_o;

  // --------------------
  // prediction
  // --------------------
  assign pred_target_o = resp_pc_q + resp_imm_i;

  always_comb begin
    pred_taken_o = 1'b0;
    if (resp_valid_i) begin
      case (resp_cf_i)
        cf_jump:   pred_taken_o = 1'b1;
        // dynamic if trained, else backward taken
        cf_branch: pred_taken_o = bht_valid_i ? bht_taken_i : resp_imm_i[31];
        default:   pred_taken_o = 1'b0;
      endcase
    end
  end

  // no request while the path changes, the response would be stale
  assign imem_req_o = (state_q == pc_run) & queue_space_i & ~flush_o & ~pred_taken_o;

  // --------------------
  // next pc, later assignments win
  // --------------------
  always_comb begin
    npc_d   = npc_q;
    state_d = state_q;
    case (state_q)
      pc_boot_load: begin
        npc_d   = boot_addr_i;
        state_d = pc_run;
      end
      default: begin
        if (imem_req_o) begin
          npc_d = npc_q + vaddr_t'(INSTR_BYTES);
        end
      end
    endcase
    if (pred_taken_o) npc_d = pred_target_o;
    if (mispredict_i) npc_d = mispredict_target_i;
    if (eret_i)       npc_d = epc_i;
    if (ex_valid_i)   npc_d = trap_vector_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= pc_boot_load;
      npc_q   <= '0;
    end else begin
      state_q <= state_d;
      npc_q   <= npc_d;
    end
  end

  // memory answers next cycle, so one slot tracks the in-flight pc
  always_ff @(posedge clk_i) begin
    if (imem_req_o) begin
      resp_pc_q <= npc_q;
    end
  end

endmodule

/* dv/frontend_tb.sv */
`timescale 1ns/100ps

module frontend_tb
  import fetch_pkg::*;
();

  localparam int unsigned TOTAL_ENTRIES = 320;
  localparam int unsigned CYCLE_LIMIT   = 40 * TOTAL_ENTRIES;
  localparam vaddr_t      BOOT_ADDR     = 32'h0000_1000;
  localparam logic [6:0]  OPCODE_ALU    = 7'b0010011;

  logic   clk_i, rst_ni;
  vaddr_t boot_addr_i;
  logic   imem_req_o, imem_valid_i;
  vaddr_t imem_addr_o;
  instr_t imem_rdata_i;
  logic   fetch_valid_o, fetch_ready_i, fetch_pred_taken_o;
  vaddr_t fetch_pc_o, fetch_pred_target_o;
  instr_t fetch_instr_o;
  logic   resolve_valid_i, resolve_branch_i, resolve_taken_i, resolve_mispredict_i;
  vaddr_t resolve_pc_i, resolve_target_i;
  logic   ex_valid_i, eret_i;
  vaddr_t trap_vector_i, epc_i;

  // run bookkeeping and per-test knobs
  logic [31:0] rng_state, salt;
  int unsigned cycles, errors, test_errors, accepted, tests_passed, tests_failed;
  int unsigned pct_branch, pct_jal, pct_ready, pct_resolve, pct_redirect;
  logic        timed_out;

  // --------------------
  // reference model state
  // --------------------
  vaddr_t   exp_next;
  // request in flight that memory answers next cycle
  logic     pend_valid;
  vaddr_t   pend_pc, pend_imm;
  instr_t   pend_word;
  cf_e      pend_cf;
  // expected queue contents toward decode
  vaddr_t   q_pc [$];
  instr_t   q_instr [$];
  logic     q_taken [$];
  vaddr_t   q_target [$];
  bht_cnt_t m_cnt [BHT_ENTRIES];
  logic     m_valid [BHT_ENTRIES];
  // head seen last cycle under back-pressure
  logic     prev_hold, prev_taken;
  vaddr_t   prev_pc, prev_target;
  instr_t   prev_instr;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  frontend uut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic chance(input int unsigned pct);
    return (next_random() % 100) < pct;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  // word derived from the whole address with the opcode forced by the test mix
  task automatic gen_word(input vaddr_t addr, output instr_t word, output vaddr_t imm,
                          output cf_e cf);
    logic [31:0] r;
    int unsigned pick;
    r    = xorshift32(xorshift32(addr ^ salt));
    pick = (r >> 8) % 100;
    // small even offset from -128 to +126
    imm  = {{25{r[6]}}, r[5:0], 1'b0};
    if (pick < pct_branch) begin
      cf   = cf_branch;
      word = {imm[12], imm[10:5], r[24:12], imm[4:1], imm[11], OPCODE_BRANCH};
    end else if (pick < pct_branch + pct_jal) begin
      cf   = cf_jump;
      word = {imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], OPCODE_JAL};
    end else begin
      cf   = cf_none;
      imm  = '0;
      word = {r[31:7], OPCODE_ALU};
    end
  endtask

  // two-bit counter whose first update starts weak in the resolved direction
  task automatic train(input bht_idx_t idx, input logic taken);
    if (!m_valid[idx]) begin
      m_valid[idx] = 1'b1;
      m_cnt[idx]   = taken ? 2'd2 : 2'd1;
    end else if (taken && m_cnt[idx] != 2'd3) begin
      m_cnt[idx] = m_cnt[idx] + 2'd1;
    end else if (!taken && m_cnt[idx] != 2'd0) begin
      m_cnt[idx] = m_cnt[idx] - 2'd1;
    end
  endtask

  // --------------------
  // one clock cycle
  // --------------------
  task automatic step();
    logic        redirect, taken, exp_req;
    vaddr_t      redir_pc, target;
    bht_idx_t    idx;
    logic [31:0] r;
    @(posedge clk_i);
    #10;
    // memory answers the request seen last cycle
    imem_valid_i         = pend_valid;
    imem_rdata_i         = pend_word;
    fetch_ready_i        = chance(pct_ready);
    r                    = next_random();
    resolve_valid_i      = chance(pct_resolve);
    resolve_pc_i         = next_random();
    resolve_branch_i     = r[1] | r[2];
    resolve_taken_i      = r[0];
    resolve_mispredict_i = chance(pct_redirect);
    resolve_target_i     = next_random() & 32'h0000_fffc;
    ex_valid_i           = chance(pct_redirect);
    trap_vector_i        = next_random() & 32'h0000_fffc;
    eret_i               = chance(pct_redirect);
    epc_i                = next_random() & 32'h0000_fffc;

    @(negedge clk_i);
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, decode stopped receiving entries", cycles);
      timed_out = 1'b1;
      test_errors++;
    end
    if (prev_hold) begin
      assert (fetch_valid_o) else begin
        $display("fetch_valid_o dropped while fetch_ready_i was low");
        test_errors++;
      end
      check_val("fetch_pc_o", prev_pc, fetch_pc_o);
      check_val("fetch_instr_o", prev_instr, fetch_instr_o);
      check_val("fetch_pred_taken_o", prev_taken, fetch_pred_taken_o);
      check_val("fetch_pred_target_o", prev_target, fetch_pred_target_o);
    end
    // accepted entry leaves the head of the model queue
    if (fetch_valid_o && fetch_ready_i) begin
      accepted++;
      assert (q_pc.size() != 0) else begin
        $display("decode accepted an entry that the model never fetched");
        test_errors++;
      end
      if (q_pc.size() != 0) begin
        check_val("fetch_pc_o", q_pc.pop_front(), fetch_pc_o);
        check_val("fetch_instr_o", q_instr.pop_front(), fetch_instr_o);
        check_val("fetch_pred_taken_o", q_taken.pop_front(), fetch_pred_taken_o);
        check_val("fetch_pred_target_o", q_target.pop_front(), fetch_pred_target_o);
      end
    end
    // exception over return over mispredict
    redirect = ex_valid_i | eret_i | (resolve_valid_i & resolve_mispredict_i);
    if (ex_valid_i) begin
      redir_pc = trap_vector_i;
    end else if (eret_i) begin
      redir_pc = epc_i;
    end else begin
      redir_pc = resolve_target_i;
    end
    taken = 1'b0;
    if (redirect) begin
      // queue flushed and arriving word dropped
      q_pc.delete();
      q_instr.delete();
      q_taken.delete();
      q_target.delete();
      exp_next = redir_pc;
    end else if (pend_valid) begin
      idx = pend_pc[5:2];
      if (pend_cf == cf_jump) begin
        taken = 1'b1;
      end else if (pend_cf == cf_branch) begin
        taken = m_valid[idx] ? m_cnt[idx][1] : pend_imm[31];
      end
      target = pend_pc + pend_imm;
      q_pc.push_back(pend_pc);
      q_instr.push_back(pend_word);
      q_taken.push_back(taken);
      q_target.push_back(target);
      if (taken) exp_next = target;
    end
    // request only on a steady path with two free slots left after this cycle
    exp_req = !redirect && !taken && (q_pc.size() <= QUEUE_DEPTH - 2);
    check_val("imem_req_o", exp_req, imem_req_o);
    // lookup above used the table before this write
    if (resolve_valid_i && resolve_branch_i) train(resolve_pc_i[5:2], resolve_taken_i);
    pend_valid = 1'b0;
    if (imem_req_o) begin
      check_val("imem_addr_o", exp_next, imem_addr_o);
      pend_valid = 1'b1;
      pend_pc    = exp_next;
      gen_word(exp_next, pend_word, pend_imm, pend_cf);
      exp_next   = exp_next + vaddr_t'(INSTR_BYTES);
    end
    prev_hold   = fetch_valid_o & ~fetch_ready_i & ~redirect;
    prev_pc     = fetch_pc_o;
    prev_instr  = fetch_instr_o;
    prev_taken  = fetch_pred_taken_o;
    prev_target = fetch_pred_target_o;
  endtask

  task automatic run_test(input string name, input int unsigned n, input int unsigned br,
                          input int unsigned jal, input int unsigned rdy,
                          input int unsigned res, input int unsigned red);
    if (!timed_out) begin
      pct_branch   = br;
      pct_jal      = jal;
      pct_ready    = rdy;
      pct_resolve  = res;
      pct_redirect = red;
      salt         = next_random();
      test_errors  = 0;
      accepted     = 0;
      while (accepted < n && !timed_out) step();
      if (test_errors == 0) begin
        tests_passed++;
        $display("test %s: ok, %0d entries", name, accepted);
      end else begin
        tests_failed++;
        $display("test %s: %0d errors in %0d entries", name, test_errors, accepted);
      end
      errors += test_errors;
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    rng_state            = 32'h80072d1f;
    boot_addr_i          = BOOT_ADDR;
    imem_valid_i         = 1'b0;
    imem_rdata_i         = '0;
    fetch_ready_i        = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_pc_i         = '0;
    resolve_branch_i     = 1'b0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = '0;
    ex_valid_i           = 1'b0;
    trap_vector_i        = '0;
    eret_i               = 1'b0;
    epc_i                = '0;
    exp_next             = BOOT_ADDR;
    pend_valid           = 1'b0;
    pend_word            = '0;
    prev_hold            = 1'b0;
    cycles               = 0;
    errors               = 0;
    tests_passed         = 0;
    tests_failed         = 0;
    timed_out            = 1'b0;
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
      m_cnt[i]   = '0;
    end
    wait (rst_ni === 1'b1);
    run_test("sequential", 20, 0, 0, 100, 0, 0);
    run_test("static_prediction", 60, 30, 20, 100, 0, 0);
    run_test("bht_training", 80, 50, 10, 100, 50, 0);
    run_test("redirects", 80, 30, 10, 80, 40, 6);
    run_test("back_pressure", 80, 25, 10, 40, 30, 0);
    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held over two rising edges, released just after the second
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

/* project.f */
design/fetch_pkg.sv
design/instr_scan.sv
design/bht.sv
design/pc_gen.sv
design/fetch_queue.sv
design/frontend.sv
dv/tb_clock_gen.sv
dv/frontend_tb.sv
